// ==== hw/zx_mem_pkg.sv ====
package zx_mem_pkg;

   // --------------------
   // sram geometry
   localparam int SRAM_AW  = 21;         // 2MB of external sram
   localparam int PAGE_AW  = 14;         // offset inside a 16K page
   localparam int CHUNK_AW = 13;         // offset inside an 8K timex chunk

   typedef logic [2:0] page_t;           // one of the eight 128K ram pages
   typedef logic [1:0] arrangement_t;    // +3 all-ram layout, 1FFD bits 2:1

   // --------------------
   // region codes, the top bits of the sram address
   localparam logic [3:0] RAM_BASE    = 4'b0000;   // pages 0..7 live at the bottom
   localparam logic [4:0] ROM_BASE    = 5'b00010;  // four 16K rom banks from 128K up
   localparam logic [3:0] DOCEXT_BASE = 4'b0011;   // dock and ext cartridge banks

   // cpu quadrants as seen on a[15:14]
   localparam logic [1:0] QUAD_ROM  = 2'b00;       // 0000-3fff
   localparam logic [1:0] QUAD_LOW  = 2'b01;       // 4000-7fff
   localparam logic [1:0] QUAD_MID  = 2'b10;       // 8000-bfff
   localparam logic [1:0] QUAD_HIGH = 2'b11;       // c000-ffff

   // --------------------
   // named ram pages used by the map tables
   localparam page_t PAGE_ALLRAM_BOT   = 3'd0;     // bottom page, arrangement 0
   localparam page_t PAGE_ALLRAM_LOW   = 3'd1;     // 4000 in arrangement 0
   localparam page_t PAGE_FAST         = 3'd2;     // uncontended page at 8000
   localparam page_t PAGE_ALLRAM_TOP   = 3'd3;     // c000 in most all-ram layouts
   localparam page_t PAGE_ALLRAM_ROM   = 3'd4;     // bottom page, other arrangements
   localparam page_t PAGE_SCREEN0      = 3'd5;     // normal screen page
   localparam page_t PAGE_ALLRAM_MID   = 3'd6;     // 8000 in arrangements 1..3
   localparam page_t PAGE_CONTENDED_HI = 3'd7;     // shadow screen page

   // arrangement codes that the tables single out
   localparam arrangement_t ARR_0 = 2'd0;
   localparam arrangement_t ARR_1 = 2'd1;
   localparam arrangement_t ARR_3 = 2'd3;

endpackage

// ==== hw/zx_port_pkg.sv ====
package zx_port_pkg;

   // --------------------
   // port addresses and partial decode keys
   localparam logic [7:0] TIMEX_PORT     = 8'hF4;  // timex mmu, full low byte match
   localparam logic [1:0] P7FFD_PLUS3_HI = 2'b01;  // a[15:14] for 7ffd on +2A/+3
   localparam logic [3:0] P1FFD_HI       = 4'b0001; // a[15:12] for 1ffd

   // --------------------
   // 7ffd register layout
   localparam int B128_PAGE_LSB = 0;   // ram page at c000
   localparam int B128_PAGE_W   = 3;
   localparam int B128_ROM      = 4;   // low rom bank bit
   localparam int B128_LOCK     = 5;   // freezes paging until reset

   // 1ffd register layout
   localparam int BP3_ALLRAM  = 0;     // special paging mode
   localparam int BP3_ARR_LSB = 1;     // all-ram arrangement, two bits
   localparam int BP3_ARR_W   = 2;
   localparam int BP3_ROM     = 2;     // high rom bank bit, shared with the arrangement

endpackage

// ==== hw/port_decode.sv ====
`timescale 1ns/1ps

module port_decode #(
   parameter bit PLUS3_PORTS = 1'b1,    // +2A/+3 decode and 1ffd present
   parameter bit TIMEX_MMU   = 1'b1     // port f4 present
) (
   input  logic [15:0] a,               // cpu address bus
   input  logic        iorq_n,
   input  logic        rd_n,
   input  logic        wr_n,
   output logic        wr_7ffd,         // level, high for the whole io write
   output logic        wr_1ffd,
   output logic        wr_timex,
   output logic        rd_timex         // io read of port f4
);
   import zx_port_pkg::*;

   logic io_wr;
   logic io_rd;
   logic timex_hit;

   assign io_wr     = !iorq_n && !wr_n;
   assign io_rd     = !iorq_n && !rd_n;
   assign timex_hit = TIMEX_MMU && (a[7:0] == TIMEX_PORT);

   always_comb begin
      if (PLUS3_PORTS) begin
         wr_7ffd = io_wr && !timex_hit && !a[1] && (a[15:14] == P7FFD_PLUS3_HI);
         wr_1ffd = io_wr && !timex_hit && !a[1] && (a[15:12] == P1FFD_HI);
      end else begin
         wr_7ffd = io_wr && !timex_hit && !a[1] && !a[15];
         wr_1ffd = 1'b0;
      end
   end

   assign wr_timex = io_wr && timex_hit;
   assign rd_timex = io_rd && timex_hit;

endmodule

// ==== hw/paging_regs.sv ====
`timescale 1ns/1ps

module paging_regs (
   input  logic                     clk,
   input  logic                     mrst_n,        // master reset, sync
   input  logic [7:0]               din,           // cpu data out
   input  logic                     wr_7ffd,
   input  logic                     wr_1ffd,
   input  logic                     wr_timex,
   output zx_mem_pkg::page_t        ram_page,      // page seen at c000
   output logic [1:0]               rom_bank,      // {1ffd bit 2, 7ffd bit 4}
   output logic                     allram,
   output zx_mem_pkg::arrangement_t arrangement,
   output logic [7:0]               timex_mmu,     // one overlay bit per 8K chunk
   output logic                     in48kmode
);
   import zx_port_pkg::*;

   // --------------------
   // register state, only the bits that something reads
   logic [B128_PAGE_W-1:0] page_q;      // 7ffd page field
   logic                   rom_lo_q;    // 7ffd rom select
   logic                   lock_q;      // 7ffd lock, sticky until reset
   logic [BP3_ROM:0]       p3_q;        // 1ffd bits 2:0
   logic [7:0]             timex_q;     // f4 chunk map

   // paging ports stop listening once locked
   logic wr_7ffd_ok;
   logic wr_1ffd_ok;

   assign wr_7ffd_ok = wr_7ffd && !lock_q;
   assign wr_1ffd_ok = wr_1ffd && !lock_q;

   always_ff @(posedge clk) begin
      if (!mrst_n) begin
         page_q   <= '0;
         rom_lo_q <= 1'b0;
         lock_q   <= 1'b0;            // reset is the only way out of 48K mode
         p3_q     <= '0;
         timex_q  <= 8'h00;
      end else begin
         if (wr_7ffd_ok) begin
            page_q   <= din[B128_PAGE_LSB +: B128_PAGE_W];
            rom_lo_q <= din[B128_ROM];
            lock_q   <= din[B128_LOCK];
         end
         if (wr_1ffd_ok) begin
            p3_q <= din[BP3_ROM:0];    // allram, arrangement and rom high bit
         end
         // timex map ignores the lock
         if (wr_timex) begin
            timex_q <= din;
         end
      end
   end

   // --------------------
   // field decode
   assign ram_page    = page_q;
   assign rom_bank    = {p3_q[BP3_ROM], rom_lo_q};
   assign allram      = p3_q[BP3_ALLRAM];
   assign arrangement = p3_q[BP3_ARR_LSB +: BP3_ARR_W];
   assign timex_mmu   = timex_q;
   assign in48kmode   = lock_q;        // locked machine behaves as a 48K

endmodule

// ==== hw/addr_translate.sv ====
`timescale 1ns/1ps

module addr_translate (
   input  logic [15:0]                   a,                 // cpu address bus
   input  logic                          mreq_n,
   input  logic                          rd_n,
   input  logic                          wr_n,
   input  logic                          inhibit_rom,       // external romcs
   input  logic                          doc_ext_option,    // picks dock or ext bank
   input  zx_mem_pkg::page_t             ram_page,
   input  logic [1:0]                    rom_bank,
   input  logic                          allram,
   input  zx_mem_pkg::arrangement_t      arrangement,
   input  logic [7:0]                    timex_mmu,
   output logic [zx_mem_pkg::SRAM_AW-1:0] sram_addr,
   output logic                          sram_we_n,
   output logic                          mem_rd,            // sram serves this read
   output logic                          access_to_screen   // contended access
);
   import zx_mem_pkg::*;

   logic [1:0] quad;          // 16K quadrant
   logic [2:0] chunk;         // 8K chunk, timex granularity
   logic       overlay;       // chunk is mapped to dock or ext
   logic       romcs;         // external rom owns the bottom quadrant
   page_t      page;          // ram page for this quadrant
   logic       writable;
   logic       contended;     // before the overlay is taken into account

   assign quad    = a[15:14];
   assign chunk   = a[15:13];
   assign overlay = timex_mmu[chunk];
   assign romcs   = inhibit_rom && (quad == QUAD_ROM);

   // --------------------
   // home page tables
   always_comb begin
      page = ram_page;                          // c000 in normal mode
      if (!allram) begin
         case (quad)
            QUAD_LOW: page = PAGE_SCREEN0;
            QUAD_MID: page = PAGE_FAST;
            default:  page = ram_page;          // rom quadrant does not use it
         endcase
      end else begin
         case (quad)
            QUAD_ROM: begin
               if (arrangement == ARR_0)
                  page = PAGE_ALLRAM_BOT;
               else
                  page = PAGE_ALLRAM_ROM;
            end
            QUAD_LOW: begin
               if (arrangement == ARR_0)
                  page = PAGE_ALLRAM_LOW;
               else if (arrangement == ARR_3)
                  page = PAGE_CONTENDED_HI;
               else
                  page = PAGE_SCREEN0;          // arrangements 1 and 2
            end
            QUAD_MID: begin
               if (arrangement == ARR_0)
                  page = PAGE_FAST;
               else
                  page = PAGE_ALLRAM_MID;
            end
            default: begin                      // c000 quadrant
               if (arrangement == ARR_1)
                  page = PAGE_CONTENDED_HI;
               else
                  page = PAGE_ALLRAM_TOP;
            end
         endcase
      end
   end

   // --------------------
   // sram address and write protection
   always_comb begin
      if (overlay) begin
         // dock/ext chunk wins over any home page
         sram_addr = {DOCEXT_BASE, doc_ext_option, chunk, a[CHUNK_AW-1:0]};
         writable  = 1'b1;
      end else if (quad == QUAD_ROM && !allram) begin
         sram_addr = {ROM_BASE, rom_bank, a[PAGE_AW-1:0]};
         writable  = 1'b0;                      // rom image is read only
      end else begin
         sram_addr = {RAM_BASE, page, a[PAGE_AW-1:0]};
         writable  = 1'b1;
      end
      // with romcs asserted the bottom 16K belongs to the expansion bus
      if (romcs)
         writable = 1'b0;
   end

   assign sram_we_n = mreq_n | wr_n | ~writable;
   assign mem_rd    = !mreq_n && !rd_n && !romcs;

   // --------------------
   // contention, odd pages and the 4000 quadrant in normal paging
   assign contended = !allram &&
                      ((quad == QUAD_LOW) || (quad == QUAD_HIGH && ram_page[0]));

   // dock and ext chunks sit off the ula bus
   assign access_to_screen = contended && !overlay;

endmodule

// ==== hw/read_mux.sv ====
`timescale 1ns/1ps

module read_mux (
   input  logic [15:0] a,              // cpu address bus
   input  logic        mreq_n,
   input  logic        rd_n,
   input  logic        inhibit_rom,
   input  logic        mem_rd,         // sram read from addr_translate
   input  logic        rd_timex,       // io read of port f4
   input  logic [7:0]  timex_mmu,
   input  logic [7:0]  sram_rdata,
   input  logic [7:0]  din_external,   // data from the expansion bus rom
   output logic [7:0]  dout,           // to cpu data in
   output logic        oe              // dout carries valid data
);
   import zx_mem_pkg::*;

   logic ext_rd;                       // memory read of 0000-3fff under romcs

   assign ext_rd = !mreq_n && !rd_n && inhibit_rom && (a[15:14] == QUAD_ROM);

   // fixed priority, external rom first
   always_comb begin
      if (ext_rd) begin
         dout = din_external;
         oe   = 1'b1;
      end else if (mem_rd) begin
         dout = sram_rdata;
         oe   = 1'b1;
      end else if (rd_timex) begin
         dout = timex_mmu;             // mmu readback
         oe   = 1'b1;
      end else begin
         dout = 8'hFF;                 // idle bus
         oe   = 1'b0;
      end
   end

endmodule

// ==== hw/zx_memory.sv ====
`timescale 1ns/1ps

module zx_memory #(
   parameter bit PLUS3_PORTS = 1'b1,    // +2A/+3 port decode with 1ffd
   parameter bit TIMEX_MMU   = 1'b1     // timex mmu at f4
) (
   input  logic                          clk,
   input  logic                          mrst_n,
   input  logic [15:0]                   a,
   input  logic [7:0]                    din,            // cpu data out
   input  logic                          mreq_n,
   input  logic                          iorq_n,
   input  logic                          rd_n,
   input  logic                          wr_n,
   input  logic                          inhibit_rom,
   input  logic [7:0]                    din_external,
   input  logic                          doc_ext_option,
   input  logic [7:0]                    sram_rdata,
   output logic [7:0]                    dout,           // cpu data in
   output logic                          oe,
   output logic [zx_mem_pkg::SRAM_AW-1:0] sram_addr,
   output logic [7:0]                    sram_wdata,
   output logic                          sram_we_n,
   output logic                          access_to_screen,
   output logic                          in48kmode
);
   import zx_mem_pkg::*;

   // --------------------
   // stage to stage nets
   logic         wr_7ffd;
   logic         wr_1ffd;
   logic         wr_timex;
   logic         rd_timex;
   page_t        ram_page;
   logic [1:0]   rom_bank;
   logic         allram;
   arrangement_t arrangement;
   logic [7:0]   timex_mmu;
   logic         mem_rd;

   // io cycle decode
   port_decode #(
      .PLUS3_PORTS (PLUS3_PORTS),
      .TIMEX_MMU   (TIMEX_MMU)
   ) i_port_decode (
      .a        (a),
      .iorq_n   (iorq_n),
      .rd_n     (rd_n),
      .wr_n     (wr_n),
      .wr_7ffd  (wr_7ffd),
      .wr_1ffd  (wr_1ffd),
      .wr_timex (wr_timex),
      .rd_timex (rd_timex)
   );

   paging_regs i_paging_regs (
      .clk         (clk),
      .mrst_n      (mrst_n),
      .din         (din),
      .wr_7ffd     (wr_7ffd),
      .wr_1ffd     (wr_1ffd),
      .wr_timex    (wr_timex),
      .ram_page    (ram_page),
      .rom_bank    (rom_bank),
      .allram      (allram),
      .arrangement (arrangement),
      .timex_mmu   (timex_mmu),
      .in48kmode   (in48kmode)
   );

   addr_translate i_addr_translate (
      .a                (a),
      .mreq_n           (mreq_n),
      .rd_n             (rd_n),
      .wr_n             (wr_n),
      .inhibit_rom      (inhibit_rom),
      .doc_ext_option   (doc_ext_option),
      .ram_page         (ram_page),
      .rom_bank         (rom_bank),
      .allram           (allram),
      .arrangement      (arrangement),
      .timex_mmu        (timex_mmu),
      .sram_addr        (sram_addr),
      .sram_we_n        (sram_we_n),
      .mem_rd           (mem_rd),
      .access_to_screen (access_to_screen)
   );

   read_mux i_read_mux (
      .a            (a),
      .mreq_n       (mreq_n),
      .rd_n         (rd_n),
      .inhibit_rom  (inhibit_rom),
      .mem_rd       (mem_rd),
      .rd_timex     (rd_timex),
      .timex_mmu    (timex_mmu),
      .sram_rdata   (sram_rdata),
      .din_external (din_external),
      .dout         (dout),
      .oe           (oe)
   );

   assign sram_wdata = din;              // write data goes straight to the sram

endmodule

// ==== verif/zx_memory_props.sv ====
`timescale 1ns/1ps

module zx_memory_props (
   input logic                          clk,
   input logic                          mrst_n,
   input logic [15:0]                   a,
   input logic                          mreq_n,
   input logic                          iorq_n,
   input logic                          rd_n,
   input logic                          oe,
   input logic [zx_mem_pkg::SRAM_AW-1:0] sram_addr,
   input logic                          sram_we_n,
   input logic                          in48kmode
);
   import zx_mem_pkg::*;

   logic       c000_ram;                // c000 access that lands in ram pages
   logic       seen_q;                  // locked page captured
   logic [6:0] page_q;                  // sram_addr[20:14] of the locked c000 page

   assign c000_ram = !mreq_n && (a[15:14] == 2'b11) && (sram_addr[20:17] == RAM_BASE);

   always_ff @(posedge clk) begin
      if (!mrst_n) begin
         seen_q <= 1'b0;
         page_q <= '0;
      end else if (in48kmode && c000_ram && !seen_q) begin
         seen_q <= 1'b1;
         page_q <= sram_addr[20:14];
      end
   end

   we_idle: assert property (@(posedge clk) disable iff (!mrst_n) mreq_n |-> sram_we_n)
      else $error("sram write strobe low outside a memory cycle");

   oe_idle: assert property (@(posedge clk) disable iff (!mrst_n)
      !(!rd_n && (!mreq_n || (!iorq_n && a[7:0] == 8'hF4))) |-> !oe)
      else $error("oe high without a memory read or an f4 read");

   locked_page: assert property (@(posedge clk) disable iff (!mrst_n)
      (in48kmode && c000_ram && seen_q) |-> (sram_addr[20:14] == page_q))
      else $error("c000 page moved while paging is locked");

endmodule

bind zx_memory zx_memory_props i_zx_memory_props (.*);

// ==== verif/tb_zx_memory.sv ====
`timescale 1ns/1ps

module tb_zx_memory;
   import zx_mem_pkg::*;

   localparam int CLK_NS      = 4;
   localparam int TEST_CYCLES = 380;    // six resets, directed sweeps, 200 random ops
   localparam int MARGIN      = 120;

   logic               clk;
   logic               mrst_n;
   logic [15:0]        a;
   logic [7:0]         din;
   logic               mreq_n;
   logic               iorq_n;
   logic               rd_n;
   logic               wr_n;
   logic               inhibit_rom;
   logic [7:0]         din_external;
   logic               doc_ext_option;
   logic [7:0]         sram_rdata;
   logic [7:0]         dout;
   logic               oe;
   logic [SRAM_AW-1:0] sram_addr;
   logic [7:0]         sram_wdata;
   logic               sram_we_n;
   logic               access_to_screen;
   logic               in48kmode;

   // --------------------
   // reference model state
   page_t       ref_page;               // 7ffd page
   logic        ref_rom_lo;             // 7ffd bit 4
   logic        ref_lock;
   logic [2:0]  ref_p3;                 // 1ffd rom high, arrangement, allram
   logic [7:0]  ref_timex;
   logic        inh;                    // inhibit_rom for the next access
   logic        doc;                    // doc_ext_option for the next access
   logic [31:0] lcg_state;

   zx_memory #(.PLUS3_PORTS(1'b1), .TIMEX_MMU(1'b1)) i_zx_memory (
      .clk (clk), .mrst_n (mrst_n), .a (a), .din (din), .mreq_n (mreq_n),
      .iorq_n (iorq_n), .rd_n (rd_n), .wr_n (wr_n), .inhibit_rom (inhibit_rom),
      .din_external (din_external), .doc_ext_option (doc_ext_option),
      .sram_rdata (sram_rdata), .dout (dout), .oe (oe), .sram_addr (sram_addr),
      .sram_wdata (sram_wdata), .sram_we_n (sram_we_n),
      .access_to_screen (access_to_screen), .in48kmode (in48kmode)
   );

   initial clk = 1'b0;
   always #(CLK_NS / 2) clk = ~clk;

   function automatic logic [15:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[31:16];          // upper half, low bits repeat too soon
   endfunction

   // sram content is a hash of its own address
   function automatic logic [7:0] sram_byte(input logic [SRAM_AW-1:0] ad);
      return ad[7:0] ^ ad[15:8] ^ {3'b000, ad[20:16]};
   endfunction

   assign sram_rdata = sram_byte(sram_addr);

   // --------------------
   // map tables
   function automatic logic [SRAM_AW-1:0] model_addr(input logic [15:0] ad);
      logic [2:0] pg;
      logic [1:0] arr;
      arr = ref_p3[2:1];
      if (ref_timex[ad[15:13]])
         return {DOCEXT_BASE, doc, ad[15:13], ad[12:0]};   // overlay beats all
      if (!ref_p3[0]) begin
         case (ad[15:14])
            2'd0:    return {ROM_BASE, ref_p3[2], ref_rom_lo, ad[13:0]};
            2'd1:    pg = 3'd5;
            2'd2:    pg = 3'd2;
            default: pg = ref_page;
         endcase
      end else begin
         case (ad[15:14])
            2'd0:    pg = (arr == 2'd0) ? 3'd0 : 3'd4;
            2'd1:    pg = (arr == 2'd0) ? 3'd1 : ((arr == 2'd3) ? 3'd7 : 3'd5);
            2'd2:    pg = (arr == 2'd0) ? 3'd2 : 3'd6;
            default: pg = (arr == 2'd1) ? 3'd7 : 3'd3;
         endcase
      end
      return {RAM_BASE, pg, ad[13:0]};
   endfunction

   function automatic logic model_writable(input logic [15:0] ad);
      if (inh && ad[15:14] == 2'd0)
         return 1'b0;                   // expansion rom owns the bottom 16K
      if (ref_timex[ad[15:13]])
         return 1'b1;
      return !(ad[15:14] == 2'd0 && !ref_p3[0]);
   endfunction

   function automatic logic model_screen(input logic [15:0] ad);
      if (ref_p3[0] || ref_timex[ad[15:13]])
         return 1'b0;
      return (ad[15:14] == 2'd1) || (ad[15:14] == 2'd3 && ref_page[0]);
   endfunction

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp) else begin
         $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
         $display("Test FAILED");
         $fatal(1, "value mismatch in %s", name);
      end
   endtask

   task automatic bus_idle();
      mreq_n = 1'b1;
      iorq_n = 1'b1;
      rd_n   = 1'b1;
      wr_n   = 1'b1;
   endtask

   task automatic apply_reset();
      @(negedge clk);
      bus_idle();
      mrst_n = 1'b0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      mrst_n     = 1'b1;
      ref_page   = '0;
      ref_rom_lo = 1'b0;
      ref_lock   = 1'b0;
      ref_p3     = '0;
      ref_timex  = '0;
      inh        = 1'b0;
      doc        = 1'b0;
   endtask

   // --------------------
   // bus cycles
   task automatic io_write(input logic [15:0] port, input logic [7:0] data);
      @(negedge clk);
      a      = port;
      din    = data;
      mreq_n = 1'b1;
      rd_n   = 1'b1;
      iorq_n = 1'b0;
      wr_n   = 1'b0;
      @(posedge clk);                   // register takes the value here
      if (port[7:0] == 8'hF4) begin
         ref_timex = data;
      end else if (!port[1] && !ref_lock) begin
         if (port[15:14] == 2'b01)
            {ref_lock, ref_rom_lo, ref_page} = {data[5], data[4], data[2:0]};
         if (port[15:12] == 4'b0001)
            ref_p3 = data[2:0];
      end
   endtask

   task automatic io_read(input string name, input logic [15:0] port);
      logic hit;
      @(negedge clk);
      a      = port;
      mreq_n = 1'b1;
      wr_n   = 1'b1;
      iorq_n = 1'b0;
      rd_n   = 1'b0;
      #1;
      hit = (port[7:0] == 8'hF4);
      check({name, " dout"}, 32'(hit ? ref_timex : 8'hFF), 32'(dout));
      check({name, " oe"}, 32'(hit), 32'(oe));
   endtask

   task automatic mem_access(input string name, input logic [15:0] ad, input logic wr);
      logic [SRAM_AW-1:0] ea;
      logic [7:0]         ext;
      logic [7:0]         wdat;
      ext  = 8'(lcg_next());
      wdat = 8'(lcg_next());
      @(negedge clk);
      a              = ad;
      din            = wdat;
      iorq_n         = 1'b1;
      mreq_n         = 1'b0;
      rd_n           = wr;
      wr_n           = !wr;
      inhibit_rom    = inh;
      doc_ext_option = doc;
      din_external   = ext;
      #1;
      ea = model_addr(ad);
      check({name, " sram_addr"}, 32'(ea), 32'(sram_addr));
      check({name, " sram_we_n"}, 32'(!(wr && model_writable(ad))), 32'(sram_we_n));
      check({name, " screen"}, 32'(model_screen(ad)), 32'(access_to_screen));
      check({name, " in48kmode"}, 32'(ref_lock), 32'(in48kmode));
      if (wr) begin
         check({name, " sram_wdata"}, 32'(wdat), 32'(sram_wdata));
         check({name, " oe"}, 32'd0, 32'(oe));
      end else begin
         check({name, " oe"}, 32'd1, 32'(oe));
         if (inh && ad[15:14] == 2'd0)
            check({name, " dout"}, 32'(ext), 32'(dout));
         else
            check({name, " dout"}, 32'(sram_byte(ea)), 32'(dout));
      end
   endtask

   // --------------------
   // directed tests
   task automatic test_reset_defaults();
      apply_reset();
      mem_access("reset 0000", 16'h0123, 1'b0);        // rom 0
      mem_access("reset 4000", 16'h4567, 1'b0);
      mem_access("reset 8000", 16'h89AB, 1'b0);
      mem_access("reset c000", 16'hCDEF, 1'b0);
      mem_access("reset rom write", 16'h0042, 1'b1);
   endtask

   task automatic test_paging_128k();
      logic [7:0] v;
      apply_reset();
      for (int pg = 0; pg < 8; pg++) begin
         v    = 8'(pg);
         v[4] = v[0];                   // walk the rom bank along with the page
         io_write(16'h7FFD, v);
         mem_access("128k c000", 16'hC000 + 16'(pg), 1'b0);
         mem_access("128k rom", 16'h1000, 1'b0);
      end
      io_write(16'h7FFD, 8'h27);        // page 7 and lock
      mem_access("locked c000", 16'hC123, 1'b0);
      io_write(16'h7FFD, 8'h12);
      io_write(16'h1FFD, 8'h07);
      mem_access("locked c000 again", 16'hC456, 1'b0);
      mem_access("locked 0000", 16'h0123, 1'b0);
      mem_access("locked 4000", 16'h4123, 1'b1);
      check("locked in48kmode", 32'd1, 32'(in48kmode));
   endtask

   task automatic test_allram();
      apply_reset();
      for (int arr = 0; arr < 4; arr++) begin
         io_write(16'h1FFD, 8'((arr << 1) | 1));
         for (int q = 0; q < 4; q++)
            mem_access("allram read", 16'((q << 14) | 16'h00A5), 1'b0);
         mem_access("allram write 0000", 16'h0077, 1'b1);
      end
   endtask

   task automatic test_timex();
      apply_reset();
      io_write(16'h7FFD, 8'h07);        // odd page so c000 is contended
      for (int m = 0; m < 2; m++) begin
         io_write(16'h00F4, (m == 0) ? 8'h33 : 8'hCC);
         io_read("timex readback", 16'h00F4);
         for (int d = 0; d < 2; d++) begin
            doc = d[0];
            for (int k = 0; k < 8; k++)
               mem_access("timex chunk", 16'((k << 13) | 16'h0155), 1'b0);
            mem_access("timex write 0000", 16'h0010, 1'b1);
            mem_access("timex write 2000", 16'h2010, 1'b1);
         end
      end
   endtask

   task automatic test_romcs();
      apply_reset();
      inh = 1'b1;
      for (int i = 0; i < 4; i++) begin
         mem_access("romcs read", lcg_next() & 16'h3FFF, 1'b0);
         mem_access("romcs write", lcg_next() & 16'h3FFF, 1'b1);
      end
      io_write(16'h1FFD, 8'h01);        // all-ram and overlay both open 0000 to writes
      io_write(16'h00F4, 8'h01);
      mem_access("romcs allram write", 16'h0100, 1'b1);
      mem_access("romcs overlay read", 16'h0100, 1'b0);
      inh = 1'b0;
   endtask

   task automatic test_random();
      logic [15:0] r;
      logic [7:0]  data;
      apply_reset();
      for (int n = 0; n < 200; n++) begin
         r    = lcg_next();
         data = 8'(lcg_next());
         case (r[2:0])
            3'd0: begin
               if (r[15:12] != 4'h0)
                  data[5] = 1'b0;       // lock only now and then
               io_write(16'h7FFD, data);
            end
            3'd1:    io_write(r[9] ? 16'h1FFD : lcg_next(), data);
            3'd2:    io_write(16'h00F4, data);
            3'd3:    io_read("random io read", r[3] ? 16'h00F4 : lcg_next());
            default: begin
               inh = (r[6:4] == 3'd0);
               doc = r[7];
               mem_access("random access", lcg_next(), r[8]);
            end
         endcase
      end
   endtask

   // watchdog
   initial begin
      #(CLK_NS * (TEST_CYCLES + MARGIN));
      $display("watchdog expired before the tests completed");
      $display("Test FAILED");
      $fatal(1, "timeout");
   end

   initial begin
      mrst_n         = 1'b0;
      a              = '0;
      din            = '0;
      mreq_n         = 1'b1;
      iorq_n         = 1'b1;
      rd_n           = 1'b1;
      wr_n           = 1'b1;
      inhibit_rom    = 1'b0;
      din_external   = 8'hFF;
      doc_ext_option = 1'b0;
      lcg_state      = 32'd95;
      inh            = 1'b0;
      doc            = 1'b0;
      test_reset_defaults();
      test_paging_128k();
      test_allram();
      test_timex();
      test_romcs();
      test_random();
      @(negedge clk);
      bus_idle();
      @(negedge clk);
      $display("Test OK");
      $finish;
   end

endmodule

// ==== files.f ====
hw/zx_mem_pkg.sv
hw/zx_port_pkg.sv
hw/port_decode.sv
hw/paging_regs.sv
hw/addr_translate.sv
hw/read_mux.sv
hw/zx_memory.sv
verif/zx_memory_props.sv
verif/tb_zx_memory.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the zx_memory testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -sv \
   --top-module tb_zx_memory \
   -f files.f \
   -o sim_zx_memory

# tee keeps the pipeline status, the log search decides the result
./obj_dir/sim_zx_memory 2>&1 | tee sim.log

if grep -q "Test FAILED" sim.log; then
   echo "simulation reported a failure"
   exit 1
fi
echo "simulation finished without failure"
